/* design/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

	// ========================================
	// Widths
	// ========================================

	localparam int XLEN   = 32; // Instruction and data word width.
	localparam int ADDR_W = 32;

	// ========================================
	// Major opcodes
	// ========================================

	typedef enum logic [6:0] {
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111
	} opcode_e;

	// Low two bits of a parcel; 11 marks a full 32-bit instruction.
	typedef enum logic [1:0] {
		Q0      = 2'b00,
		Q1      = 2'b01,
		Q2      = 2'b10,
		NOT_RVC = 2'b11
	} rvc_quadrant_e;

	// ========================================
	// Register indices and funct3 fields
	// ========================================

	localparam logic [4:0] REG_X0 = 5'd0;
	localparam logic [4:0] REG_RA = 5'd1;
	localparam logic [4:0] REG_SP = 5'd2; // Base of C.ADDI4SPN.

	localparam logic [2:0] FUNCT3_ADD   = 3'b000;
	localparam logic [2:0] FUNCT3_SLL   = 3'b001;
	localparam logic [2:0] FUNCT3_LW_SW = 3'b010;
	localparam logic [2:0] FUNCT3_BEQ   = 3'b000;
	localparam logic [2:0] FUNCT3_BNE   = 3'b001;

endpackage

`default_nettype wire

/* design/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// ========================================
	// Realign buffer
	// ========================================

	localparam int BUF_WORDS = 2;
	localparam int BUF_CNT_W = $clog2(BUF_WORDS + 1); // Count runs from 0 to BUF_WORDS.
	localparam logic [BUF_CNT_W-1:0] BUF_FULL = BUF_CNT_W'(BUF_WORDS);

	typedef enum logic [1:0] {
		RD_NONE = 2'd0,
		RD_HALF = 2'd1, // One compressed parcel.
		RD_WORD = 2'd2
	} rd_size_e;

	// ========================================
	// Datapath structs
	// ========================================

	typedef struct packed {
		logic [riscv_pkg::XLEN-1:0]   instr; // Low halfword is the oldest one.
		logic [riscv_pkg::ADDR_W-1:0] addr;
	} parcel_t;

	typedef struct packed {
		logic [riscv_pkg::XLEN-1:0]   instr;
		logic [riscv_pkg::ADDR_W-1:0] addr;
		logic                         compressed;
		logic                         illegal;
	} fetch_out_t;

endpackage

`default_nettype wire

/* design/realign_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module realign_buffer (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          clear_i,
	input  logic                          read_offset_i,

	input  logic                          write_en_i,
	input  logic [riscv_pkg::XLEN-1:0]    word_i,
	input  logic [riscv_pkg::ADDR_W-1:0]  word_addr_i,

	input  fetch_pkg::rd_size_e           rd_size_i,
	output fetch_pkg::parcel_t            parcel_o,

	output logic                          full_o,
	output logic                          empty_o
);

	logic [riscv_pkg::XLEN-1:0]   words [fetch_pkg::BUF_WORDS];
	logic [riscv_pkg::ADDR_W-1:0] addrs [fetch_pkg::BUF_WORDS];

	logic [fetch_pkg::BUF_CNT_W-1:0] count;
	logic [fetch_pkg::BUF_CNT_W-1:0] count_after_pop;
	logic                            half_ptr; // Halfword offset inside the head word.

	logic [1:0]                    rd_halves;
	logic [1:0]                    ptr_sum;
	logic [1:0]                    need_halves;
	logic [fetch_pkg::BUF_CNT_W:0] avail_halves;
	logic                          pop;
	logic                          wr_idx;

	// ========================================
	// Read side
	// ========================================

	always_comb begin
		case (rd_size_i)
			fetch_pkg::RD_HALF: rd_halves = 2'd1;
			fetch_pkg::RD_WORD: rd_halves = 2'd2;
			default:            rd_halves = 2'd0;
		endcase
	end

	assign ptr_sum = {1'b0, half_ptr} + rd_halves;
	assign pop     = ptr_sum[1]; // Crossing into the next word frees the head.

	// The window straddles both entries when reading from the upper half.
	assign parcel_o.instr = half_ptr ? {words[1][15:0], words[0][31:16]} : words[0];
	assign parcel_o.addr  = {addrs[0][riscv_pkg::ADDR_W-1:2], half_ptr, 1'b0};

	always_comb begin
		if (count == '0) begin
			avail_halves = '0;
		end else begin
			avail_halves = {count, 1'b0} - {{fetch_pkg::BUF_CNT_W{1'b0}}, half_ptr};
		end
	end

	assign need_halves = (parcel_o.instr[1:0] == 2'b11) ? 2'd2 : 2'd1;
	assign empty_o     = avail_halves < {{(fetch_pkg::BUF_CNT_W-1){1'b0}}, need_halves};
	assign full_o      = (count == fetch_pkg::BUF_FULL);

	// ========================================
	// Write side and storage
	// ========================================

	assign count_after_pop = count - {{(fetch_pkg::BUF_CNT_W-1){1'b0}}, pop};
	assign wr_idx          = count_after_pop[0];

	always_ff @(posedge clk) begin
		if (pop) begin
			words[0] <= words[1];
			addrs[0] <= addrs[1];
		end
		if (write_en_i) begin
			words[wr_idx] <= word_i; // Lands behind whatever survives the pop.
			addrs[wr_idx] <= word_addr_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count    <= '0;
			half_ptr <= 1'b0;
		end else if (clear_i) begin
			count    <= '0;
			half_ptr <= read_offset_i; // Odd-halfword targets skip the first half.
		end else begin
			count    <= count_after_pop + {{(fetch_pkg::BUF_CNT_W-1){1'b0}}, write_en_i};
			half_ptr <= ptr_sum[0];
		end
	end

	// ========================================
	// Assertions
	// ========================================

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		(write_en_i && full_o && !clear_i) |-> pop)
		else $error("Word written into a full realign buffer.");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_size_i != fetch_pkg::RD_NONE) |-> !empty_o)
		else $error("Read from realign buffer without a complete instruction.");

endmodule

`default_nettype wire

/* design/rvc_decompressor.sv */
`timescale 1ns/100ps
`default_nettype none

module rvc_decompressor (
	input  logic [riscv_pkg::XLEN-1:0] instr_i,
	output logic [riscv_pkg::XLEN-1:0] instr_o,
	output logic                       compressed_o,
	output logic                       illegal_o
);

	logic [4:0] rd;
	logic [4:0] rs2;
	logic [4:0] rd_p;  // x8..x15 from bits 4:2.
	logic [4:0] rs1_p; // x8..x15 from bits 9:7.
	logic [2:0] funct3;
	logic       sign;

	assign rd     = instr_i[11:7];
	assign rs2    = instr_i[6:2];
	assign rd_p   = {2'b01, instr_i[4:2]};
	assign rs1_p  = {2'b01, instr_i[9:7]};
	assign funct3 = instr_i[15:13];
	assign sign   = instr_i[12];

	always_comb begin
		instr_o      = '0;
		compressed_o = 1'b1;
		illegal_o    = 1'b0;

		case (riscv_pkg::rvc_quadrant_e'(instr_i[1:0]))
			// ========================================
			// Quadrant 0
			// ========================================
			riscv_pkg::Q0: begin
				case (funct3)
					3'b000: begin
						// C.ADDI4SPN; a zero immediate is reserved.
						instr_o = {2'b00, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6],
							2'b00, riscv_pkg::REG_SP, riscv_pkg::FUNCT3_ADD, rd_p,
							riscv_pkg::OP_IMM};
						illegal_o = (instr_i[12:5] == 8'd0);
					end
					3'b010: begin
						instr_o = {5'd0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00, rs1_p,
							riscv_pkg::FUNCT3_LW_SW, rd_p, riscv_pkg::LOAD}; // C.LW.
					end
					3'b110: begin
						instr_o = {5'd0, instr_i[5], instr_i[12], rd_p, rs1_p,
							riscv_pkg::FUNCT3_LW_SW, instr_i[11:10], instr_i[6], 2'b00,
							riscv_pkg::STORE}; // C.SW.
					end
					default: illegal_o = 1'b1;
				endcase
			end

			// ========================================
			// Quadrant 1
			// ========================================
			riscv_pkg::Q1: begin
				case (funct3)
					3'b000: begin
						instr_o = {{6{sign}}, sign, instr_i[6:2], rd, riscv_pkg::FUNCT3_ADD, rd,
							riscv_pkg::OP_IMM}; // C.ADDI, C.NOP when rd is x0.
					end
					3'b010: begin
						instr_o = {{6{sign}}, sign, instr_i[6:2], riscv_pkg::REG_X0,
							riscv_pkg::FUNCT3_ADD, rd, riscv_pkg::OP_IMM}; // C.LI.
					end
					3'b011: begin
						// rd of x2 is C.ADDI16SP, which is not supported.
						instr_o = {{14{sign}}, sign, instr_i[6:2], rd, riscv_pkg::LUI};
						illegal_o = (rd == riscv_pkg::REG_SP) ||
							({sign, instr_i[6:2]} == 6'd0);
					end
					3'b101: begin
						instr_o = {sign, instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
							instr_i[2], instr_i[11], instr_i[5:3], sign, {8{sign}},
							riscv_pkg::REG_X0, riscv_pkg::JAL}; // C.J.
					end
					3'b110, 3'b111: begin
						instr_o = {sign, {3{sign}}, instr_i[6:5], instr_i[2], riscv_pkg::REG_X0,
							rs1_p, funct3[0] ? riscv_pkg::FUNCT3_BNE : riscv_pkg::FUNCT3_BEQ,
							instr_i[11:10], instr_i[4:3], sign, riscv_pkg::BRANCH};
					end
					default: illegal_o = 1'b1;
				endcase
			end

			// ========================================
			// Quadrant 2
			// ========================================
			riscv_pkg::Q2: begin
				case (funct3)
					3'b000: begin
						instr_o = {7'd0, instr_i[6:2], rd, riscv_pkg::FUNCT3_SLL, rd,
							riscv_pkg::OP_IMM};
						illegal_o = sign; // shamt[5] is reserved on RV32.
					end
					3'b100: begin
						if (!sign && rs2 == riscv_pkg::REG_X0) begin
							instr_o = {12'd0, rd, riscv_pkg::FUNCT3_ADD, riscv_pkg::REG_X0,
								riscv_pkg::JALR}; // C.JR.
							illegal_o = (rd == riscv_pkg::REG_X0);
						end else if (!sign) begin
							instr_o = {7'd0, rs2, riscv_pkg::REG_X0, riscv_pkg::FUNCT3_ADD, rd,
								riscv_pkg::OP}; // C.MV.
						end else if (rs2 != riscv_pkg::REG_X0) begin
							instr_o = {7'd0, rs2, rd, riscv_pkg::FUNCT3_ADD, rd,
								riscv_pkg::OP}; // C.ADD.
						end else begin
							illegal_o = 1'b1;
						end
					end
					default: illegal_o = 1'b1;
				endcase
			end

			default: begin
				instr_o      = instr_i;
				compressed_o = 1'b0;
			end
		endcase

		if (illegal_o) begin
			instr_o = '0;
		end
	end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
	input  logic                         clk,
	input  logic                         rst_n,

	input  logic                         req_i,
	input  logic                         retire_inst_i,
	input  logic                         target_valid_i,
	input  logic [riscv_pkg::ADDR_W-1:0] target_addr_i,

	output fetch_pkg::fetch_out_t        fetch_out_o,
	output logic                         instr_valid_o,

	output logic                         imem_valid_o,
	output logic [riscv_pkg::ADDR_W-1:0] imem_addr_o,
	input  logic                         imem_ready_i,
	input  logic [riscv_pkg::XLEN-1:0]   imem_rdata_i
);

	fetch_pkg::parcel_t   parcel;
	fetch_pkg::rd_size_e  rd_size;

	logic [riscv_pkg::XLEN-1:0]   decomp_instr;
	logic                         compressed;
	logic                         illegal;
	logic                         buf_full;
	logic                         buf_empty;

	logic [riscv_pkg::ADDR_W-1:0] fetch_addr;
	logic [riscv_pkg::ADDR_W-1:0] fetch_addr_inc;
	logic [riscv_pkg::ADDR_W-1:0] target_word;

	logic fetch_en_q;
	logic take_next;
	logic load_out;
	logic word_accept;

	// ========================================
	// Memory request
	// ========================================

	assign fetch_addr_inc = fetch_addr + 32'd4;
	assign target_word    = {target_addr_i[riscv_pkg::ADDR_W-1:2], 2'b00};

	assign imem_valid_o = fetch_en_q & ((req_i & ~buf_full) | target_valid_i);
	assign imem_addr_o  = target_valid_i ? target_word :
		(imem_ready_i ? fetch_addr_inc : fetch_addr);

	// A word returned during a redirect belongs to the old stream.
	assign word_accept = imem_valid_o & imem_ready_i & ~target_valid_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_en_q <= 1'b0; // Fetch starts the cycle after reset is released.
			fetch_addr <= '0;
		end else begin
			fetch_en_q <= 1'b1;
			if (target_valid_i) begin
				fetch_addr <= target_word;
			end else if (imem_valid_o && imem_ready_i) begin
				fetch_addr <= fetch_addr_inc;
			end
		end
	end

	// ========================================
	// Buffer and decompressor
	// ========================================

	assign take_next = ~instr_valid_o | retire_inst_i;
	assign load_out  = take_next & ~buf_empty & ~target_valid_i;
	assign rd_size   = load_out ? (compressed ? fetch_pkg::RD_HALF : fetch_pkg::RD_WORD) :
		fetch_pkg::RD_NONE;

	realign_buffer u_buffer (
		.clk           (clk),
		.rst_n         (rst_n),
		.clear_i       (target_valid_i),
		.read_offset_i (target_addr_i[1]),
		.write_en_i    (word_accept),
		.word_i        (imem_rdata_i),
		.word_addr_i   (fetch_addr),
		.rd_size_i     (rd_size),
		.parcel_o      (parcel),
		.full_o        (buf_full),
		.empty_o       (buf_empty)
	);

	rvc_decompressor u_decomp (
		.instr_i      (parcel.instr),
		.instr_o      (decomp_instr),
		.compressed_o (compressed),
		.illegal_o    (illegal)
	);

	// ========================================
	// Output register
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_valid_o <= 1'b0;
		end else if (target_valid_i) begin
			instr_valid_o <= 1'b0;
		end else if (take_next) begin
			instr_valid_o <= ~buf_empty;
		end
	end

	always_ff @(posedge clk) begin
		if (load_out) begin
			fetch_out_o.instr      <= decomp_instr;
			fetch_out_o.addr       <= parcel.addr;
			fetch_out_o.compressed <= compressed;
			fetch_out_o.illegal    <= illegal;
		end
	end

	a_redirect_flush: assert property (@(posedge clk) disable iff (!rst_n)
		target_valid_i |=> !instr_valid_o && buf_empty &&
			(parcel.addr[1] == $past(target_addr_i[1])))
		else $error("Output or realign buffer not flushed after a redirect.");

endmodule

`default_nettype wire

/* testbench/tb_imem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_imem_model (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        throttle_i,
	input  logic        valid_i,
	input  logic [31:0] addr_i,
	output logic        ready_o,
	output logic [31:0] rdata_o
);

	logic [31:0] mem [64]; // Filled and loaded by the testbench.
	logic [31:0] addr_q;
	logic [31:0] next_addr;
	logic [31:0] lfsr;
	logic        take;
	logic        rst_s;
	logic        throttle_s;

	function automatic logic [31:0] step_lfsr(input logic [31:0] state);
		logic [31:0] nxt;
		nxt = state >> 1;
		if (state[0]) begin
			nxt = nxt ^ 32'h8020_0003;
		end
		return nxt;
	endfunction

	assign rdata_o = mem[addr_q[7:2]]; // Word at the DUT's current fetch address.

	initial begin
		addr_q  = '0;
		ready_o = 1'b0;
		lfsr    = 32'h8c7;
	end

	// The DUT's address is settled by the falling edge; it is applied after the next rise.
	always begin
		@(negedge clk);
		take       = valid_i || !ready_o;
		next_addr  = addr_i;
		rst_s      = rst_n;
		throttle_s = throttle_i;
		@(posedge clk);
		#2;
		if (!rst_s) begin
			addr_q  = '0;
			ready_o = 1'b0;
		end else begin
			if (take) begin
				addr_q = next_addr;
			end
			if (throttle_s) begin
				ready_o = lfsr[0]; // One bit per cycle.
				lfsr    = step_lfsr(lfsr);
			end else begin
				ready_o = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_stage;

	typedef struct packed {
		logic [7:0]            tag;
		logic [31:0]           arg;
		fetch_pkg::fetch_out_t exp;
	} step_t;

	logic                  clk;
	logic                  rst_n;
	logic                  req_i;
	logic                  retire_inst_i;
	logic                  target_valid_i;
	logic [31:0]           target_addr_i;
	fetch_pkg::fetch_out_t fetch_out_o;
	logic                  instr_valid_o;
	logic                  imem_valid_o;
	logic [31:0]           imem_addr_o;
	logic                  imem_ready_i;
	logic [31:0]           imem_rdata_i;
	logic                  throttle;

	step_t       steps[$];
	logic [31:0] lfsr_state = 32'h8c7;
	bit          retire_rand;
	bit          file_ok;
	int          errors;
	int          checks;
	int          tests;
	int          test_checks;
	int          test_errors;
	int          cycles;
	int          limit = 1000000;

	fetch_stage u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.req_i          (req_i),
		.retire_inst_i  (retire_inst_i),
		.target_valid_i (target_valid_i),
		.target_addr_i  (target_addr_i),
		.fetch_out_o    (fetch_out_o),
		.instr_valid_o  (instr_valid_o),
		.imem_valid_o   (imem_valid_o),
		.imem_addr_o    (imem_addr_o),
		.imem_ready_i   (imem_ready_i),
		.imem_rdata_i   (imem_rdata_i)
	);

	tb_imem_model u_imem (
		.clk        (clk),
		.rst_n      (rst_n),
		.throttle_i (throttle),
		.valid_i    (imem_valid_o),
		.addr_i     (imem_addr_o),
		.ready_o    (imem_ready_i),
		.rdata_o    (imem_rdata_i)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: the expected stream did not finish within %0d cycles.", limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_lfsr(input logic [31:0] state);
		logic [31:0] nxt;
		nxt = state >> 1;
		if (state[0]) begin
			nxt = nxt ^ 32'h8020_0003;
		end
		return nxt;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ========================================
	// Golden file
	// ========================================

	task automatic read_golden(output bit ok);
		int          fd;
		int          code;
		int          c_flag;
		int          i_flag;
		byte         tag;
		logic [31:0] a;
		logic [31:0] b;
		string       line;
		step_t       s;
		ok = 1'b0;
		fd = $fopen("testbench/fetch_golden.txt", "r");
		if (fd == 0) begin
			return;
		end
		ok = 1'b1;
		limit = 200;
		for (int w = 0; w < 64; w++) begin
			u_imem.mem[w] = 32'h13 | (32'(w) << 20); // addi x0, x0 with the word address.
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) begin
				break;
			end
			s = '0;
			s.tag = tag;
			case (tag)
				"#": code = $fgets(line, fd);
				"M": begin
					code = $fscanf(fd, "%h %h", a, b);
					u_imem.mem[a[7:2]] = b;
				end
				"E": begin
					code = $fscanf(fd, "%h %h %d %d", a, b, c_flag, i_flag);
					s.exp.addr       = a;
					s.exp.instr      = b;
					s.exp.compressed = c_flag[0];
					s.exp.illegal    = i_flag[0];
					limit += 40;
					steps.push_back(s);
				end
				default: begin
					code = $fscanf(fd, "%h", a);
					s.arg = a;
					if (tag == "H") begin
						limit += int'(a);
					end
					steps.push_back(s);
				end
			endcase
		end
		$fclose(fd);
	endtask

	// ========================================
	// Stimulus
	// ========================================

	task automatic finish_test();
		$display("Test %0d done: %0d checks, %0d errors", tests, checks - test_checks,
			errors - test_errors);
	endtask

	task automatic redirect(input logic [31:0] target);
		retire_inst_i  = 1'b0;
		target_valid_i = 1'b1;
		target_addr_i  = target;
		@(posedge clk);
		#2;
		target_valid_i = 1'b0;
		check_value({31'd0, instr_valid_o}, 32'd0, "instr_valid_o after redirect");
	endtask

	task automatic hold_retire(input int n);
		retire_inst_i = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#2;
		end
		check_value({31'd0, imem_valid_o}, 32'd0, "imem_valid_o with a full buffer");
	endtask

	task automatic retire_expected(input fetch_pkg::fetch_out_t exp);
		bit got;
		bit take;
		got = 1'b0;
		while (!got) begin
			retire_inst_i = 1'b0;
			take = 1'b1;
			if (retire_rand) begin
				take       = lfsr_state[0];
				lfsr_state = next_lfsr(lfsr_state);
			end
			if (instr_valid_o && take) begin
				check_value(fetch_out_o.addr, exp.addr, "address");
				check_value(fetch_out_o.instr, exp.instr,
					$sformatf("instruction at %h", exp.addr));
				check_value({31'd0, fetch_out_o.compressed}, {31'd0, exp.compressed},
					$sformatf("compressed flag at %h", exp.addr));
				check_value({31'd0, fetch_out_o.illegal}, {31'd0, exp.illegal},
					$sformatf("illegal flag at %h", exp.addr));
				retire_inst_i = 1'b1;
				got = 1'b1;
			end
			@(posedge clk);
			#2;
		end
		retire_inst_i = 1'b0;
	endtask

	initial begin
		rst_n          = 1'b0;
		req_i          = 1'b0;
		retire_inst_i  = 1'b0;
		target_valid_i = 1'b0;
		target_addr_i  = '0;
		throttle       = 1'b0;
		cycles         = 0;
		read_golden(file_ok);
		if (!file_ok) begin
			$display("Could not open the golden file testbench/fetch_golden.txt.");
			$display(">>> FAIL");
		end else begin
			repeat (10) @(posedge clk);
			#2;
			rst_n = 1'b1;
			req_i = 1'b1;
			foreach (steps[k]) begin
				case (steps[k].tag)
					"S": begin
						if (tests > 0) begin
							finish_test();
						end
						tests++;
						test_checks = checks;
						test_errors = errors;
						throttle    = steps[k].arg[4]; // Hex 10 throttles memory ready.
						retire_rand = steps[k].arg[0];
					end
					"T": redirect(steps[k].arg);
					"H": hold_retire(int'(steps[k].arg));
					default: retire_expected(steps[k].exp);
				endcase
			end
			finish_test();
			$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
			if (errors == 0 && checks > 0) begin
				$display(">>> PASS");
			end else begin
				$display(">>> FAIL");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/fetch_golden.txt */
# M addr word | S mode (hex 10 random ready, 01 random retire) | T target | H stall cycles (hex)
# E addr instr compressed illegal, in retire order
M 00 00100093
M 04 00200113
M 08 002081b3
M 0c 0000a203
M 40 02934515
M 44 85aa0070
M 48 404495aa
M 4c 0001c404
M 50 060e0040
M 54 c4016685
M 58 00c68733
M 80 57fd0000
M 84 6105a000
M 88 e0028082
M 8c 00100093
M 90 fcfda011
S 00
E 00 00100093 0 0
E 04 00200113 0 0
E 08 002081b3 0 0
E 0c 0000a203 0 0
S 00
T 40
E 40 00500513 1 0
E 42 00700293 0 0
E 46 00a005b3 1 0
E 48 00a585b3 1 0
E 4a 00442483 1 0
E 4c 00942423 1 0
E 4e 00000013 1 0
E 50 00410413 1 0
E 52 00361613 1 0
E 54 000016b7 1 0
E 56 00040463 1 0
E 58 00c68733 0 0
S 00
T 80
E 80 00000000 1 1
E 82 fff00793 1 0
E 84 00000000 1 1
E 86 00000000 1 1
E 88 00008067 1 0
E 8a 00000000 1 1
E 8c 00100093 0 0
E 90 0040006f 1 0
E 92 fe049fe3 1 0
S 00
T 00
E 00 00100093 0 0
E 04 00200113 0 0
T 46
E 46 00a005b3 1 0
E 48 00a585b3 1 0
T 52
E 52 00361613 1 0
E 54 000016b7 1 0
S 11
T 40
E 40 00500513 1 0
E 42 00700293 0 0
E 46 00a005b3 1 0
E 48 00a585b3 1 0
H 28
E 4a 00442483 1 0
E 4c 00942423 1 0
E 4e 00000013 1 0
E 50 00410413 1 0

/* sim.f */
design/riscv_pkg.sv
design/fetch_pkg.sv
design/realign_buffer.sv
design/rvc_decompressor.sv
design/fetch_stage.sv
testbench/tb_imem_model.sv
testbench/tb_fetch_stage.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= tb_fetch_stage
RTL_TOP    ?= fetch_stage
FILELIST   ?= sim.f
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
